// ==== bench/pce_audio_model.svh ====
// Reference model of the audio output path
//  fixed-fraction source cuts
//  headroom mix, CD double-add, 5/4 range fill
//  soft-knee master boost for one channel
//  full stereo path from the inputs to audio

`ifndef PCE_AUDIO_MODEL_SVH
`define PCE_AUDIO_MODEL_SVH

// 1/2 + 1/4 + 1/2^third of the sample, rounding toward minus infinity
function automatic sample_t model_cut(input sample_t s, input int third);
	int v;
	v = int'(s);
	return sample_t'((v >>> 1) + (v >>> 2) + (v >>> third));
endfunction

function automatic wide_sample_t model_sum(input sample_t psg_s, input sample_t adpcm_s,
	input sample_t cd_s, input logic cd_twice);
	int           total;
	int           scaled;
	wide_sample_t w;
	total = int'(model_cut(psg_s, psg_third_shift)) + int'(model_cut(adpcm_s, adpcm_third_shift));
	total = total + int'(cd_s);
	if (cd_twice)
		total = total + int'(cd_s);	// CD boost
	w      = wide_sample_t'(total);
	scaled = int'(w);
	if (!cd_twice)
		scaled = scaled + (scaled >>> 2);	// Five quarters
	return wide_sample_t'(scaled);
endfunction

function automatic sample_t model_boost(input wide_sample_t w, input logic [1:0] boost);
	int top;
	int mag;
	int knee;
	int base;
	int gain;
	int falloff;
	int level;
	top = int'(w) >>> 2;	// Keep the upper 16 of 18 bits
	if (boost == 2'd0)
		return sample_t'(top);
	if (boost[1]) begin
		knee    = int'(knee_x4);
		base    = int'(base_x4);
		gain    = gain_x4;
		falloff = falloff_x4;
	end else begin
		knee    = int'(knee_x2);
		base    = int'(base_x2);
		gain    = gain_x2;
		falloff = falloff_x2;
	end
	mag = (top < 0) ? -top : top;
	if (mag < knee)
		level = mag * gain;
	else
		level = (mag - knee) / falloff + base;
	if (top < 0)
		level = -level;
	return sample_t'(level);
endfunction

function automatic stereo_t model_audio(input stereo_t psg_s, input sample_t adpcm_s,
	input stereo_t cd_s, input mix_cfg_t c);
	stereo_t out_s;
	out_s.left  = model_boost(model_sum(psg_s.left, adpcm_s, cd_s.left, c.cd_boost),
		c.master_boost);
	out_s.right = model_boost(model_sum(psg_s.right, adpcm_s, cd_s.right, c.cd_boost),
		c.master_boost);
	return out_s;
endfunction

`endif

// ==== bench/pce_audio_tb.sv ====
// Testbench for the console audio output path
//  clock, reset and LFSR stimulus in phases of fixed configuration
//  input delay line and reference model comparison by assertions
//  both x4 curve encodings fed the same samples
//  watchdog and final report

`default_nettype none

module pce_audio_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import pce_audio_pkg::*;

	`include "pce_audio_model.svh"

	localparam int clk_period   = 4;
	localparam int phase_cycles = 400;
	localparam int num_phases   = 8;
	localparam int watchdog_ns  = num_phases * phase_cycles * clk_period + 400;

	localparam logic [31:0] lfsr_seed = 32'h713f_69e3;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;	// x^32+x^22+x^2+x+1

	// Stimulus kinds
	localparam int stim_full       = 0;
	localparam int stim_small      = 1;
	localparam int stim_mirror     = 2;
	localparam int stim_left_quiet = 3;

	typedef struct packed {
		logic       small_in;
		logic       mirror;	// Negated copy of the previous sample
		logic       left_quiet;
		logic       replay;
		logic [8:0] step;
	} tag_t;

	typedef struct packed {
		logic     live;
		mix_cfg_t cfg;
		stereo_t  psg;
		sample_t  adpcm;
		stereo_t  cdda;
		tag_t     tag;
	} entry_t;

	logic        clk_sys;
	logic        reset;
	mix_cfg_t    cfg;
	stereo_t     psg;
	sample_t     adpcm;
	stereo_t     cdda;
	stereo_t     audio;
	tag_t        tag;
	logic [31:0] lfsr_state;

	entry_t   line [0:mix_latency-1];	// Inputs as the DUT sampled them
	entry_t   tail;
	int       settle;
	logic     check_ok;
	int       checks;
	int       errors = 0;
	mix_cfg_t plain_cfg;
	mix_cfg_t x4_cfg;
	stereo_t  expected;
	stereo_t  plain;
	stereo_t  doubled;
	stereo_t  unmirrored;
	stereo_t  mirrored;
	stereo_t  x4_ref;
	stereo_t  adpcm_only;

	pce_audio_top u_pce_audio_top (
		.clk_sys(clk_sys),
		.reset  (reset),
		.cfg    (cfg),
		.psg    (psg),
		.adpcm  (adpcm),
		.cdda   (cdda),
		.audio  (audio)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Random stimulus
	////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? lfsr_taps : 32'h0);
	endfunction

	// Signed sample of nbits, one LFSR step per bit
	task automatic draw_sample(input int nbits, output sample_t value);
		logic [15:0] raw;
		raw = '0;
		for (int i = 0; i < nbits; i++) begin
			raw        = {raw[14:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		value = sample_t'(raw << (16 - nbits)) >>> (16 - nbits);
	endtask

	// Multiples of 256 keep every shift exact, so negation carries through
	task automatic draw_coarse(output sample_t value);
		draw_sample(8, value);
		value = value <<< 8;
		if (value == 16'sh8000)
			value = 16'sh7f00;
	endtask

	task automatic run_phase(input mix_cfg_t phase_cfg, input int kind,
		input logic rec, input logic rep);
		sample_t pl;
		sample_t pr;
		sample_t ad;
		sample_t cl;
		sample_t cr;
		tag_t    next_tag;
		if (rec || rep)
			lfsr_state = lfsr_seed;	// Same samples for both x4 encodings
		for (int step = 0; step < phase_cycles; step++) begin
			next_tag        = '0;
			next_tag.step   = 9'(step);
			next_tag.replay = rep;
			case (kind)
				stim_small: begin
					draw_sample(11, pl);
					draw_sample(11, pr);
					draw_sample(11, ad);
					draw_sample(11, cl);
					draw_sample(11, cr);
					next_tag.small_in = 1'b1;
				end
				stim_mirror: begin
					if ((step % 2) == 0) begin
						draw_coarse(pl);
						draw_coarse(pr);
						draw_coarse(ad);
						draw_coarse(cl);
						draw_coarse(cr);
					end else begin
						pl = -pl;
						pr = -pr;
						ad = -ad;
						cl = -cl;
						cr = -cr;
						next_tag.mirror = 1'b1;
					end
				end
				stim_left_quiet: begin
					pl = '0;
					cl = '0;
					draw_sample(16, pr);
					draw_sample(16, ad);
					draw_sample(16, cr);
					next_tag.left_quiet = 1'b1;
				end
				default: begin
					draw_sample(16, pl);
					draw_sample(16, pr);
					draw_sample(16, ad);
					draw_sample(16, cl);
					draw_sample(16, cr);
				end
			endcase
			@(posedge clk_sys);
			cfg   <= phase_cfg;
			psg   <= '{left: pl, right: pr};
			adpcm <= ad;
			cdda  <= '{left: cl, right: cr};
			tag   <= next_tag;
		end
	endtask

	////////////////////////////////////////
	// Delay line and expected values
	////////////////////////////////////////

	function automatic stereo_t negate_stereo(input stereo_t s);
		stereo_t n;
		n.left  = -s.left;
		n.right = -s.right;
		return n;
	endfunction

	always @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < mix_latency; i++)
				line[i] <= '0;
			settle <= 0;
			checks <= 0;
		end else begin
			line[0] <= '{live: 1'b1, cfg: cfg, psg: psg, adpcm: adpcm, cdda: cdda, tag: tag};
			for (int i = 1; i < mix_latency; i++)
				line[i] <= line[i - 1];
			if (cfg != line[0].cfg)
				settle <= mix_latency;	// Pipeline holds mixed settings
			else if (settle != 0)
				settle <= settle - 1;
			if (check_ok)
				checks <= checks + 1;
		end
	end

	always_comb begin
		tail                   = line[mix_latency-1];
		check_ok               = tail.live && (settle == 0) && !reset;
		expected               = model_audio(tail.psg, tail.adpcm, tail.cdda, tail.cfg);
		plain_cfg              = tail.cfg;
		plain_cfg.master_boost = boost_none;
		plain                  = model_audio(tail.psg, tail.adpcm, tail.cdda, plain_cfg);
		doubled.left           = sample_t'(plain.left * 2);
		doubled.right          = sample_t'(plain.right * 2);
		// Positive copy through the model, then flipped
		unmirrored             = model_audio(negate_stereo(tail.psg), -tail.adpcm,
			negate_stereo(tail.cdda), tail.cfg);
		mirrored               = negate_stereo(unmirrored);
		x4_cfg                 = tail.cfg;
		x4_cfg.master_boost    = boost_x4;
		x4_ref                 = model_audio(tail.psg, tail.adpcm, tail.cdda, x4_cfg);
		adpcm_only             = model_audio('0, tail.adpcm, '0, tail.cfg);
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	a_reset_zero: assert property (@(posedge clk_sys) reset |=> (audio == '0))
		else begin
			errors = errors + 1;
			$display("FAILED at %0t: audio not silent after reset, got %h", $time,
				$sampled(audio));
		end

	a_model_match: assert property (@(posedge clk_sys) disable iff (reset)
		check_ok |-> (audio == expected))
		else begin
			errors = errors + 1;
			$display("FAILED at %0t: audio %0d/%0d, expected %0d/%0d", $time,
				$sampled(audio.left), $sampled(audio.right),
				$sampled(expected.left), $sampled(expected.right));
		end

	a_small_doubled: assert property (@(posedge clk_sys) disable iff (reset)
		(check_ok && line[mix_latency-1].tag.small_in) |-> (audio == doubled))
		else begin
			errors = errors + 1;
			$display("FAILED at %0t: x2 output %0d/%0d, twice plain is %0d/%0d", $time,
				$sampled(audio.left), $sampled(audio.right),
				$sampled(doubled.left), $sampled(doubled.right));
		end

	a_mirror_sign: assert property (@(posedge clk_sys) disable iff (reset)
		(check_ok && line[mix_latency-1].tag.mirror) |-> (audio == mirrored))
		else begin
			errors = errors + 1;
			$display("FAILED at %0t: negated input gave %0d/%0d, expected %0d/%0d", $time,
				$sampled(audio.left), $sampled(audio.right),
				$sampled(mirrored.left), $sampled(mirrored.right));
		end

	a_x4_encodings: assert property (@(posedge clk_sys) disable iff (reset)
		(check_ok && line[mix_latency-1].tag.replay) |-> (audio == x4_ref))
		else begin
			errors = errors + 1;
			$display("FAILED at %0t: boost 3 gave %h, x4 curve gives %h", $time,
				$sampled(audio), $sampled(x4_ref));
		end

	a_left_alone: assert property (@(posedge clk_sys) disable iff (reset)
		(check_ok && line[mix_latency-1].tag.left_quiet) |-> (audio.left == adpcm_only.left))
		else begin
			errors = errors + 1;
			$display("FAILED at %0t: left %0d, ADPCM alone gives %0d", $time,
				$sampled(audio.left), $sampled(adpcm_only.left));
		end

	////////////////////////////////////////
	// Sequence and report
	////////////////////////////////////////

	initial begin
		reset      <= 1'b1;
		cfg        <= '0;
		psg        <= '0;
		adpcm      <= '0;
		cdda       <= '0;
		tag        <= '0;
		lfsr_state = lfsr_seed;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		run_phase('{cd_boost: 1'b0, master_boost: boost_none}, stim_full, 1'b0, 1'b0);
		run_phase('{cd_boost: 1'b1, master_boost: boost_none}, stim_full, 1'b0, 1'b0);
		run_phase('{cd_boost: 1'b0, master_boost: boost_x2}, stim_small, 1'b0, 1'b0);
		run_phase('{cd_boost: 1'b0, master_boost: boost_x2}, stim_full, 1'b0, 1'b0);
		run_phase('{cd_boost: 1'b0, master_boost: boost_x2}, stim_mirror, 1'b0, 1'b0);
		run_phase('{cd_boost: 1'b0, master_boost: boost_x4}, stim_full, 1'b1, 1'b0);
		run_phase('{cd_boost: 1'b0, master_boost: boost_t'(2'd3)}, stim_full, 1'b0, 1'b1);
		run_phase('{cd_boost: 1'b1, master_boost: boost_x4}, stim_left_quiet, 1'b0, 1'b0);

		repeat (mix_latency + 2) @(posedge clk_sys);	// Drain the pipeline

		$display("Checked cycles: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		#watchdog_ns;
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+bench
hdl/pce_audio_pkg.sv
hdl/source_attenuator.sv
hdl/audio_summer.sv
hdl/range_compressor.sv
hdl/pce_audio_top.sv
bench/pce_audio_tb.sv

// ==== hdl/audio_summer.sv ====
// Headroom mixer for all audio sources
//  CD audio delay register, aligns with the attenuated sources
//  18-bit sum with optional second CD add
//  5/4 range fill when the CD boost is off
//  two cycles of latency

`default_nettype none

module audio_summer (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  pce_audio_pkg::mix_cfg_t     cfg,
	input  pce_audio_pkg::stereo_t      psg_att,
	input  pce_audio_pkg::stereo_t      adpcm_att,
	input  pce_audio_pkg::stereo_t      cdda,
	output pce_audio_pkg::wide_stereo_t mix
);
	import pce_audio_pkg::*;

	stereo_t      cdda_q;	// Same stage as the attenuator outputs
	wide_stereo_t pre;	// Raw 18-bit sum

	////////////////////////////////////////
	// Channel arithmetic
	////////////////////////////////////////

	function automatic wide_sample_t widen(input sample_t s);
		return {{2{s[15]}}, s};
	endfunction

	// CD boost adds the CD sample a second time
	function automatic wide_sample_t sum_channel(
		input sample_t psg,
		input sample_t adpcm,
		input sample_t cd,
		input logic    cd_twice
	);
		wide_sample_t cd_w;
		wide_sample_t cd_extra;
		cd_w     = widen(cd);
		cd_extra = cd_twice ? cd_w : '0;
		return widen(psg) + widen(adpcm) + cd_w + cd_extra;
	endfunction

	// Without the boost the sum only reaches 3/4 of the range
	function automatic wide_sample_t fill_range(input wide_sample_t w, input logic cd_twice);
		wide_sample_t quarter;
		quarter = w >>> 2;
		return cd_twice ? w : w + quarter;
	endfunction

	////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cdda_q <= '0;
			pre    <= '0;
			mix    <= '0;
		end else begin
			cdda_q <= cdda;

			// Stage 1, the sum
			pre.left  <= sum_channel(psg_att.left, adpcm_att.left, cdda_q.left,
				cfg.cd_boost);
			pre.right <= sum_channel(psg_att.right, adpcm_att.right, cdda_q.right,
				cfg.cd_boost);

			// Stage 2, range scaling
			mix.left  <= fill_range(pre.left, cfg.cd_boost);
			mix.right <= fill_range(pre.right, cfg.cd_boost);
		end
	end

	// Source cuts leave enough headroom that scaling never wraps,
	// as long as both stages saw the same CD boost setting
	a_no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
		$stable(cfg.cd_boost) |=>
			(mix.left[17] == $past(pre.left[17]) &&
			 mix.right[17] == $past(pre.right[17])))
		else $error("mix scaling wrapped");

endmodule

`default_nettype wire

// ==== hdl/pce_audio_pkg.sv ====
// Audio output path shared definitions
//  sample and mix accumulator types
//  stereo pairs as packed structs
//  mixer configuration and master boost encoding
//  source attenuation shifts, soft-knee curve constants
//  input to output pipeline latency

`default_nettype none

package pce_audio_pkg;

	////////////////////////////////////////
	// Sample types
	////////////////////////////////////////

	typedef logic signed [15:0] sample_t;
	typedef logic signed [17:0] wide_sample_t;	// Two guard bits for the mix

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef struct packed {
		wide_sample_t left;
		wide_sample_t right;
	} wide_stereo_t;

	////////////////////////////////////////
	// Configuration
	////////////////////////////////////////

	// Master boost; upper bit picks the x4 curve, so 3 acts as x4
	typedef enum logic [1:0] {
		boost_none = 2'd0,
		boost_x2   = 2'd1,
		boost_x4   = 2'd2
	} boost_t;

	typedef struct packed {
		logic   cd_boost;	// CD audio counted twice, no 5/4 fill
		boost_t master_boost;
	} mix_cfg_t;

	////////////////////////////////////////
	// Constants
	////////////////////////////////////////

	// Source cuts are 1/2 + 1/4 + 1/2^third_shift
	localparam int psg_third_shift   = 4;	// 13/16 of full scale
	localparam int adpcm_third_shift = 3;	// 7/8 of full scale

	// Knee sits at 32767*(f-1)/(f*g-1)+1 so the upper segment
	// lands just at full scale
	localparam logic [15:0] knee_x2    = 16'd14044;
	localparam logic [15:0] base_x2    = 16'd28088;	// knee times gain
	localparam int          gain_x2    = 2;
	localparam int          falloff_x2 = 4;

	localparam logic [15:0] knee_x4    = 16'd7400;
	localparam logic [15:0] base_x4    = 16'd29600;
	localparam int          gain_x4    = 4;
	localparam int          falloff_x4 = 8;

	// Attenuator 1, summer 2, compressor 1
	localparam int mix_latency = 4;

endpackage

`default_nettype wire

// ==== hdl/pce_audio_top.sv ====
// Console audio output path
//  PSG and ADPCM attenuators
//  headroom summer with CD audio
//  per-channel master boost compressors

`default_nettype none

module pce_audio_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  pce_audio_pkg::mix_cfg_t cfg,
	input  pce_audio_pkg::stereo_t  psg,
	input  pce_audio_pkg::sample_t  adpcm,
	input  pce_audio_pkg::stereo_t  cdda,
	output pce_audio_pkg::stereo_t  audio
);
	import pce_audio_pkg::*;

	stereo_t      adpcm_dup;	// Mono ADPCM on both sides
	stereo_t      psg_att;
	stereo_t      adpcm_att;
	wide_stereo_t mix;

	assign adpcm_dup = '{left: adpcm, right: adpcm};

	////////////////////////////////////////
	// Source cuts
	////////////////////////////////////////

	source_attenuator #(
		.third_shift(psg_third_shift)
	) u_psg_att (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.src       (psg),
		.attenuated(psg_att)
	);

	source_attenuator #(
		.third_shift(adpcm_third_shift)
	) u_adpcm_att (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.src       (adpcm_dup),
		.attenuated(adpcm_att)
	);

	////////////////////////////////////////
	// Mix and master boost
	////////////////////////////////////////

	audio_summer u_summer (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cfg      (cfg),
		.psg_att  (psg_att),
		.adpcm_att(adpcm_att),
		.cdda     (cdda),	// Registered once inside the summer
		.mix      (mix)
	);

	range_compressor u_comp_l (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.boost     (cfg.master_boost),
		.mix_in    (mix.left),
		.sample_out(audio.left)
	);

	range_compressor u_comp_r (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.boost     (cfg.master_boost),
		.mix_in    (mix.right),
		.sample_out(audio.right)
	);

	// Silence in gives silence out exactly mix_latency cycles later,
	// whatever the configuration
	a_silence_latency: assert property (@(posedge clk_sys) disable iff (reset)
		(psg == '0 && adpcm == '0 && cdda == '0) |-> ##mix_latency (audio == '0))
		else $error("audio path latency or silence broken");

endmodule

`default_nettype wire

// ==== hdl/range_compressor.sv ====
// Master boost for one channel
//  keeps the top 16 of the 18 mix bits
//  soft-knee x2 or x4 curve on the magnitude, sign restored after
//  bypass when no boost is selected
//  one cycle of latency in every mode

`default_nettype none

module range_compressor (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  pce_audio_pkg::boost_t       boost,
	input  pce_audio_pkg::wide_sample_t mix_in,
	output pce_audio_pkg::sample_t      sample_out
);
	import pce_audio_pkg::*;

	sample_t     trunc;	// Top 16 mix bits
	logic        neg;
	logic [15:0] mag;	// Unsigned, -32768 gives 32768
	logic [15:0] knee;
	logic [15:0] base;
	logic [15:0] gain;
	logic [3:0]  fall_shift;
	logic [15:0] curve_mag;
	sample_t     curve;
	logic [15:0] out_mag;

	assign trunc = mix_in[17:2];
	assign neg   = trunc[15];
	assign mag   = neg ? 16'd0 - trunc : trunc;

	////////////////////////////////////////
	// Curve selection
	////////////////////////////////////////

	// Upper boost bit picks the x4 curve, value 3 included
	assign knee       = boost[1] ? knee_x4 : knee_x2;
	assign base       = boost[1] ? base_x4 : base_x2;
	assign gain       = boost[1] ? 16'(gain_x4) : 16'(gain_x2);
	assign fall_shift = boost[1] ? 4'($clog2(falloff_x4)) : 4'($clog2(falloff_x2));

	// Linear gain below the knee, gentle slope above
	// All of it wraps at 16 bits
	always_comb begin
		if (mag < knee)
			curve_mag = mag * gain;
		else
			curve_mag = ((mag - knee) >> fall_shift) + base;
	end

	assign curve = neg ? 16'd0 - curve_mag : curve_mag;

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			sample_out <= '0;
		else if (boost == boost_none)
			sample_out <= trunc;	// Plain 16-bit mix
		else
			sample_out <= curve;
	end

	assign out_mag = sample_out[15] ? 16'd0 - sample_out : sample_out;

	// Below the knee the boost must never make a sample quieter
	a_knee_gain: assert property (@(posedge clk_sys) disable iff (reset)
		(boost != boost_none && mag < knee) |=> (out_mag >= $past(mag)))
		else $error("compressor lost level below knee");

endmodule

`default_nettype wire

// ==== hdl/source_attenuator.sv ====
// Registered fixed-fraction attenuator for one stereo source
//  cut is 1/2 + 1/4 + 1/2^third_shift per channel
//  one cycle of latency

`default_nettype none

module source_attenuator #(
	parameter int third_shift = 4
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  pce_audio_pkg::stereo_t src,
	output pce_audio_pkg::stereo_t attenuated
);
	import pce_audio_pkg::*;

	// Arithmetic shifts keep the sign, result wraps at 16 bits
	function automatic sample_t cut(input sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> third_shift);
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			attenuated <= '0;
		end else begin
			attenuated.left  <= cut(src.left);
			attenuated.right <= cut(src.right);
		end
	end

	// Fraction stays below one, so a nonzero input never flips sign
	a_sign_kept_l: assert property (@(posedge clk_sys) disable iff (reset)
		(src.left != '0) |=> (attenuated.left[15] == $past(src.left[15])))
		else $error("attenuator left sign flipped");

	a_sign_kept_r: assert property (@(posedge clk_sys) disable iff (reset)
		(src.right != '0) |=> (attenuated.right[15] == $past(src.right[15])))
		else $error("attenuator right sign flipped");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the audio path testbench with Verilator and runs it.
# The run passes only if the testbench printed its pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
	-f build.f \
	--top-module pce_audio_tb \
	-Mdir obj_dir \
	-o pce_audio_sim

output=$(./obj_dir/pce_audio_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "No errors"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
